//--- src/cps2_pkg.sv
/*
 * CPS2 decryption shared package
 * Widths, latencies and the structs used on the fetch path
 * and between decrypt pipeline stages
 */
package cps2_pkg;

    localparam int RAW_BYTES  = 20;                     // Bytes in one full key load
    localparam int RAW_W      = RAW_BYTES * 8;          // Raw loader shift register
    localparam int LOAD_CNT_W = $clog2(RAW_BYTES + 1);  // Load counter, saturates at RAW_BYTES
    localparam int ROUNDS     = 4;                      // Feistel rounds
    localparam int LATENCY    = ROUNDS + 1;             // Gate stage plus one per round

    typedef logic [7:0]  byte_t;      // Key byte or Feistel half
    typedef logic [15:0] word_t;      // Program word
    typedef logic [63:0] key_t;       // Decryption key
    typedef logic [15:0] addr_rng_t;  // Upper limit of the encrypted area
    typedef logic [22:0] cpu_addr_t;  // 68k word address

    // Fetch request from the CPU side
    typedef struct packed {
        logic      valid;
        logic      opcode;  // Opcode fetch, data reads never decrypt
        cpu_addr_t addr;
        word_t     data;    // Word as read from ROM
    } fetch_req_t;

    // Fetch response back to the CPU
    typedef struct packed {
        logic  valid;
        logic  decrypted;   // Word went through the rounds
        word_t data;
    } fetch_rsp_t;

    // Carried between pipeline stages
    typedef struct packed {
        logic  valid;
        logic  decrypt;     // Clear means bypass lane
        byte_t lo_addr;     // Feeds subkey A in every round
        byte_t left;
        byte_t right;
    } stage_t;

endpackage

//--- src/cps2_keyload.sv
/*
 * CPS2 key loader
 * Takes key bytes on rising edges of din_we and scatters the
 * raw bits into the 64-bit key and the 16-bit address limit
 */
module cps2_keyload (
    input  logic                clk,
    input  logic                rst,
    input  cps2_pkg::byte_t     din,
    input  logic                din_we,
    output cps2_pkg::key_t      key,
    output cps2_pkg::addr_rng_t addr_rng,
    output logic                key_valid
);
    import cps2_pkg::*;

    // Bit scatter of the original loader. Ten 16-bit fields from the top,
    // each made of six bits of one byte, a whole byte, then two bits
    function automatic logic [RAW_W-1:0] scatter(input logic [RAW_W-1:0] r);
        logic [RAW_W-1:0] c;
        int base;
        int tail;
        int msb;
        c = '0;
        for (int f = 0; f < 10; f++) begin
            base = (f < 6) ? 16 * f : 240 - 16 * f;  // Limit fields walk up, key fields down
            tail = (base + RAW_W - 8) % RAW_W;       // Byte below base, wraps for field 0
            msb  = RAW_W - 1 - 16 * f;
            for (int p = 0; p < 6; p++) begin
                c[msb - p] = r[base + 10 + p];       // Upper six bits of the neighbor byte
            end
            for (int p = 0; p < 8; p++) begin
                c[msb - 6 - p] = r[base + p];        // Full byte, LSB first
            end
            for (int p = 0; p < 2; p++) begin
                c[msb - 14 - p] = r[tail + p];       // Two low bits of the byte below
            end
        end
        return c;
    endfunction

    logic                  last_we;  // Strobe history
    logic                  take;     // Rising strobe edge
    logic [RAW_W-1:0]      raw;
    logic [RAW_W-1:0]      cfg;
    logic [LOAD_CNT_W-1:0] cnt;      // Bytes seen since reset

    assign take = din_we && !last_we;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_we <= 1'b0;
            raw     <= '0;
            cnt     <= '0;
        end else begin
            last_we <= din_we;
            if (take) begin
                raw <= {din, raw[RAW_W-1:8]};  // New byte at the top, oldest drops out
                if (cnt != LOAD_CNT_W'(RAW_BYTES)) begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

    assign cfg       = scatter(raw);
    assign key       = cfg[63:0];
    assign addr_rng  = cfg[RAW_W-1 -: 16];  // Top field of the table
    assign key_valid = (cnt == LOAD_CNT_W'(RAW_BYTES));  // Stays up once saturated

endmodule

//--- src/cps2_range_gate.sv
/*
 * CPS2 range gate, pipeline stage 0
 * Registers each fetch request and decides decrypt or bypass
 */
module cps2_range_gate (
    input  logic                clk,
    input  logic                rst,
    input  cps2_pkg::fetch_req_t req,
    input  cps2_pkg::addr_rng_t addr_rng,
    input  logic                key_valid,
    output cps2_pkg::stage_t    stage
);
    import cps2_pkg::*;

    stage_t nxt;
    logic   valid_q;
    logic   decrypt_q;
    byte_t  lo_q;
    byte_t  left_q;
    byte_t  right_q;

    always_comb begin
        nxt.valid   = req.valid;
        nxt.decrypt = req.valid && req.opcode      // Only opcode fetches
                      && (req.addr[22:7] < addr_rng)  // Limit counts 128-word blocks
                      && key_valid;                // No decrypt before a full load
        nxt.lo_addr = req.addr[7:0];
        nxt.left    = req.data[15:8];
        nxt.right   = req.data[7:0];
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q   <= 1'b0;
            decrypt_q <= 1'b0;
        end else begin
            valid_q   <= nxt.valid;
            decrypt_q <= nxt.decrypt;
        end
    end

    always_ff @(posedge clk) begin
        lo_q    <= nxt.lo_addr;
        left_q  <= nxt.left;
        right_q <= nxt.right;
    end

    assign stage = '{valid: valid_q, decrypt: decrypt_q, lo_addr: lo_q,
                     left: left_q, right: right_q};

endmodule

//--- src/cps2_feistel_round.sv
/*
 * CPS2 Feistel round
 * One registered round, subkeys from key bytes 2*ROUND and
 * 2*ROUND+1 mixed with the low address byte. Bypass lane keeps
 * the halves when decrypt is clear
 */
module cps2_feistel_round #(
    parameter int ROUND = 0
) (
    input  logic             clk,
    input  logic             rst,
    input  cps2_pkg::key_t   key,
    input  cps2_pkg::stage_t din,
    output cps2_pkg::stage_t dout
);
    import cps2_pkg::*;

    byte_t ska;      // Subkey A, address dependent
    byte_t skb;      // Subkey B
    byte_t mix;
    byte_t f_out;    // Round function
    byte_t new_left;
    byte_t new_right;
    logic  valid_q;
    logic  decrypt_q;
    byte_t lo_q;
    byte_t left_q;
    byte_t right_q;

    always_comb begin
        ska   = key[16*ROUND +: 8] ^ din.lo_addr;  // Key byte n sits at key[8n+7:8n]
        skb   = key[16*ROUND + 8 +: 8];
        mix   = din.right ^ ska;
        f_out = ((mix << (ROUND + 1)) | (mix >> (7 - ROUND))) ^ skb;  // Rotate left ROUND+1
        if (din.decrypt) begin
            new_left  = din.right;
            new_right = din.left ^ f_out;
        end else begin
            new_left  = din.left;   // Bypass
            new_right = din.right;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q   <= 1'b0;
            decrypt_q <= 1'b0;
        end else begin
            valid_q   <= din.valid;
            decrypt_q <= din.decrypt;
        end
    end

    always_ff @(posedge clk) begin
        lo_q    <= din.lo_addr;
        left_q  <= new_left;
        right_q <= new_right;
    end

    assign dout = '{valid: valid_q, decrypt: decrypt_q, lo_addr: lo_q,
                    left: left_q, right: right_q};

endmodule

//--- src/cps2_decrypt_pipe.sv
/*
 * CPS2 decrypt pipeline
 * Four Feistel rounds in series after the gate stage,
 * last round output relabelled as the fetch response
 */
module cps2_decrypt_pipe (
    input  logic                 clk,
    input  logic                 rst,
    input  cps2_pkg::key_t       key,
    input  cps2_pkg::stage_t     stage,
    output cps2_pkg::fetch_rsp_t rsp
);
    import cps2_pkg::*;

    stage_t chain [0:ROUNDS];  // chain[0] from the gate, chain[ROUNDS] final

    assign chain[0] = stage;

    for (genvar r = 0; r < ROUNDS; r++) begin : g_round
        cps2_feistel_round #(
            .ROUND (r)
        ) u_round (
            .clk  (clk),
            .rst  (rst),
            .key  (key),         // Key as it stands at this stage
            .din  (chain[r]),
            .dout (chain[r+1])
        );
    end

    // No extra register here, round 3 already lands at LATENCY
    assign rsp.valid     = chain[ROUNDS].valid;
    assign rsp.decrypted = chain[ROUNDS].decrypt;
    assign rsp.data      = {chain[ROUNDS].left, chain[ROUNDS].right};

endmodule

//--- src/cps2_decrypt_top.sv
/*
 * CPS2 program decryption top
 * Serial key loader, range gate and decrypt pipeline
 * on the opcode fetch path
 */
module cps2_decrypt_top (
    input  logic                 clk,
    input  logic                 rst,
    input  cps2_pkg::byte_t      din,
    input  logic                 din_we,
    input  cps2_pkg::fetch_req_t req,
    output cps2_pkg::fetch_rsp_t rsp,
    output logic                 key_valid
);
    import cps2_pkg::*;

    key_t      key;
    addr_rng_t addr_rng;
    stage_t    gate_stage;  // Stage 0 output

    cps2_keyload u_keyload (
        .clk       (clk),
        .rst       (rst),
        .din       (din),
        .din_we    (din_we),
        .key       (key),
        .addr_rng  (addr_rng),
        .key_valid (key_valid)
    );

    cps2_range_gate u_gate (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .addr_rng  (addr_rng),
        .key_valid (key_valid),
        .stage     (gate_stage)
    );

    cps2_decrypt_pipe u_pipe (
        .clk   (clk),
        .rst   (rst),
        .key   (key),
        .stage (gate_stage),
        .rsp   (rsp)
    );

endmodule

//--- bench/cps2_decrypt_props.sv
/*
 * CPS2 fetch path properties
 * Fixed latency, no orphan responses, key_valid stability
 * and decrypt gating, bound onto the decryption top
 */
module cps2_decrypt_props (
    input logic                 clk,
    input logic                 rst,
    input cps2_pkg::fetch_req_t req,
    input cps2_pkg::fetch_rsp_t rsp,
    input logic                 key_valid
);
    timeunit 1ns;
    timeprecision 100ps;
    import cps2_pkg::*;

    // Gate stage plus four rounds, never stalls
    a_latency : assert property (@(posedge clk) disable iff (rst)
        req.valid |-> ##LATENCY rsp.valid)
        else $error("rsp.valid missing %0d cycles after a request", LATENCY);

    // Every response traces back to a request
    a_no_orphan : assert property (@(posedge clk) disable iff (rst)
        rsp.valid |-> $past(req.valid, LATENCY))
        else $error("rsp.valid with no request %0d cycles earlier", LATENCY);

    // Load counter saturates, so the key stays usable
    a_key_hold : assert property (@(posedge clk) disable iff (rst)
        !$fell(key_valid))
        else $error("key_valid fell outside reset");

    a_dec_key : assert property (@(posedge clk) disable iff (rst)
        rsp.decrypted |-> key_valid)
        else $error("decrypted response without a loaded key");

endmodule

bind cps2_decrypt_top cps2_decrypt_props u_props (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .rsp       (rsp),
    .key_valid (key_valid)
);

//--- bench/cps2_decrypt_tb.sv
/*
 * CPS2 decryption testbench
 * Loads keys over the strobe port, runs fetches through the pipeline
 * and checks every response against a reference model
 */
module cps2_decrypt_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import cps2_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int DRIVE_DLY  = 2;      // Input skew after the rising edge
    localparam int SEED       = 14595;
    localparam int RESET_CYC  = 8;
    // Upper bounds on the cycles each test takes including the drain
    localparam int T1_CYC = 40;
    localparam int T2_CYC = 120;        // 20 bytes at up to 5 cycles each
    localparam int T3_CYC = 170;        // 48 fetches with gaps up to 2
    localparam int T4_CYC = 50;
    localparam int T5_CYC = 90;
    localparam int T6_CYC = 150;
    localparam int TOTAL_CYC = RESET_CYC + T1_CYC + T2_CYC + T3_CYC + T4_CYC + T5_CYC + T6_CYC;
    localparam int MARGIN_CYC = 200;

    typedef struct packed {
        fetch_rsp_t  rsp;
        logic [31:0] due;               // Cycle the response must show up
        cpu_addr_t   addr;              // For messages only
    } exp_t;

    logic       clk = 1'b0;
    logic       rst;
    byte_t      din;
    logic       din_we;
    fetch_req_t req;
    fetch_rsp_t rsp;
    logic       key_valid;

    int         cyc = 0;                // Rising edges seen
    exp_t       exp_q[$];               // Expected responses in order
    logic [RAW_W-1:0] ref_raw;          // Model copy of the raw register
    int         ref_cnt;
    key_t       ref_key;
    addr_rng_t  ref_limit;
    int         n_checks = 0;
    int         n_errors = 0;
    int         rsp_seen = 0;
    int         tests_run = 0;
    int         tests_failed = 0;
    string      test_name;
    int         chk0;
    int         err0;

    cps2_decrypt_top u_dut (
        .clk       (clk),
        .rst       (rst),
        .din       (din),
        .din_we    (din_we),
        .req       (req),
        .rsp       (rsp),
        .key_valid (key_valid)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    task automatic value_error(input string msg);
        $display("[ERROR] %0d ns: %s", $time, msg);
        n_errors++;
    endtask

    task automatic flow_error(input string msg);
        $display("At %0d ns something went wrong: %s", $time, msg);
        n_errors++;
    endtask

    task automatic check_bit(input string what, input logic seen, input logic want);
        n_checks++;
        if (seen !== want) begin
            value_error($sformatf("%s expected %b seen %b", what, want, seen));
        end
    endtask

    // Key loader scatter written per destination bit
    function automatic logic [RAW_W-1:0] build_config(input logic [RAW_W-1:0] r);
        logic [RAW_W-1:0] c;
        int base_tab [10];
        int base;
        int tail;
        int src;
        c = '0;
        base_tab = '{0, 16, 32, 48, 64, 80, 144, 128, 112, 96};  // Field 0 is the limit
        for (int f = 0; f < 10; f++) begin
            base = base_tab[f];
            tail = (base == 0) ? RAW_W - 8 : base - 8;           // Byte below wraps to the top
            for (int j = 0; j < 16; j++) begin
                if (j >= 10) begin
                    src = base + 25 - j;      // Top six bits of the next byte up
                end else if (j >= 2) begin
                    src = base + 9 - j;       // Whole byte in reversed order
                end else begin
                    src = tail + 1 - j;       // Two low bits of the byte below
                end
                c[144 - 16 * f + j] = r[src];
            end
        end
        return c;
    endfunction

    task automatic ref_shift(input byte_t b);
        logic [RAW_W-1:0] cfg;
        ref_raw = {b, ref_raw[RAW_W-1:8]};
        if (ref_cnt < RAW_BYTES) begin
            ref_cnt++;
        end
        cfg       = build_config(ref_raw);
        ref_limit = cfg[RAW_W-1:RAW_W-16];
        ref_key   = cfg[63:0];
    endtask

    function automatic byte_t key_byte(input key_t k, input int n);
        return byte_t'(k >> (8 * n));
    endfunction

    function automatic byte_t rotl8(input byte_t x, input int n);
        logic [15:0] dbl;
        dbl = {x, x} << n;
        return dbl[15:8];
    endfunction

    // Reference for one fetch with the gate rule then four rounds
    function automatic fetch_rsp_t expect_rsp(input logic op, input cpu_addr_t a,
                                              input word_t d);
        fetch_rsp_t r;
        byte_t      l;
        byte_t      rt;
        byte_t      t;
        byte_t      f;
        logic       dec;
        dec = op && (a[22:7] < ref_limit) && (ref_cnt == RAW_BYTES);
        l   = d[15:8];
        rt  = d[7:0];
        if (dec) begin
            for (int k = 0; k < ROUNDS; k++) begin
                f  = rotl8(rt ^ key_byte(ref_key, 2 * k) ^ a[7:0], k + 1)
                     ^ key_byte(ref_key, 2 * k + 1);
                t  = rt;
                rt = l ^ f;
                l  = t;
            end
        end
        r.valid     = 1'b1;
        r.decrypted = dec;
        r.data      = {l, rt};
        return r;
    endfunction

    task automatic step();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic fetch(input logic op, input cpu_addr_t a, input word_t d);
        exp_t e;
        req   = '{valid: 1'b1, opcode: op, addr: a, data: d};
        e.rsp = expect_rsp(op, a, d);
        e.due = cyc + LATENCY;          // Sampled next edge and out four edges later
        e.addr = a;
        exp_q.push_back(e);
        step();
    endtask

    task automatic idle(input int n);
        req = '0;
        repeat (n) step();
    endtask

    function automatic cpu_addr_t below_addr();
        logic [15:0] blk;
        blk = (ref_limit == 0) ? 16'h0 : 16'($urandom % ref_limit);
        return {blk, 7'($urandom)};
    endfunction

    function automatic cpu_addr_t above_addr();
        int unsigned span;
        span = 65536 - ref_limit;
        return {16'(ref_limit + ($urandom % span)), 7'($urandom)};
    endfunction

    task automatic load_byte(input byte_t b, input int hold);
        din    = b;
        din_we = 1'b1;
        ref_shift(b);                   // Taken on the next edge
        for (int h = 0; h < hold; h++) begin
            step();
            check_bit("key_valid", key_valid, ref_cnt == RAW_BYTES);
            din = byte_t'($urandom);    // Junk while held that must not load
        end
        din_we = 1'b0;
        step();
    endtask

    task automatic load_key(input int max_hold);
        for (int i = 0; i < RAW_BYTES; i++) begin
            load_byte(byte_t'($urandom), 1 + $urandom % max_hold);
        end
        $display("key %h limit %h", ref_key, ref_limit);
    endtask

    task automatic drain();
        int n;
        n   = 0;
        req = '0;
        while (exp_q.size() > 0 && n < 2 * LATENCY) begin
            step();
            n++;
        end
        if (exp_q.size() != 0) begin
            flow_error($sformatf("pipeline did not drain, %0d responses missing", exp_q.size()));
            exp_q.delete();
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        chk0      = n_checks;
        err0      = n_errors;
    endtask

    task automatic finish_test();
        int errs;
        drain();
        errs = n_errors - err0;
        tests_run++;
        if (errs != 0) begin
            tests_failed++;
        end
        $display("%-26s %4d checks %3d errors  %s", test_name, n_checks - chk0, errs,
                 (errs == 0) ? "pass" : "FAIL");
    endtask

    // Comparer samples mid cycle where rsp is settled
    always @(negedge clk) begin
        exp_t e;
        if (!rst) begin
            if (rsp.valid) begin
                rsp_seen++;
                if (exp_q.size() == 0) begin
                    flow_error($sformatf("response %h came with no request in flight", rsp));
                end else begin
                    e = exp_q.pop_front();
                    n_checks++;
                    if (cyc != e.due) begin
                        flow_error($sformatf("response for addr %h came at cycle %0d, not %0d",
                                             e.addr, cyc, e.due));
                    end
                    if (rsp !== e.rsp) begin
                        value_error($sformatf("addr %h expected dec=%b data=%h seen dec=%b data=%h",
                                              e.addr, e.rsp.decrypted, e.rsp.data,
                                              rsp.decrypted, rsp.data));
                    end
                end
            end else if (exp_q.size() > 0 && exp_q[0].due <= cyc) begin
                e = exp_q.pop_front();
                flow_error($sformatf("no response for the request at addr %h", e.addr));
            end
        end
    end

    initial begin
        #(longint'(TOTAL_CYC + MARGIN_CYC) * CLK_PERIOD);
        $display("Run timed out after %0d cycles", TOTAL_CYC + MARGIN_CYC);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        int seen0;
        void'($urandom(SEED));
        rst     = 1'b1;
        din     = '0;
        din_we  = 1'b0;
        req     = '0;
        ref_raw = '0;
        ref_cnt = 0;
        ref_key = '0;
        ref_limit = '0;
        repeat (RESET_CYC) @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b0;

        start_test("reset and no key");
        check_bit("rsp.valid", rsp.valid, 1'b0);
        check_bit("key_valid", key_valid, 1'b0);
        for (int i = 0; i < 16; i++) begin
            fetch(1'b1, cpu_addr_t'($urandom), word_t'($urandom));  // Pass through
        end
        finish_test();

        start_test("key load with long strobes");
        load_key(4);
        check_bit("key_valid", key_valid, 1'b1);
        finish_test();

        start_test("opcode below limit");
        for (int i = 0; i < 48; i++) begin
            fetch(1'b1, below_addr(), word_t'($urandom));
            idle($urandom % 3);
        end
        finish_test();

        start_test("gate rule and boundary");
        for (int i = 0; i < 8; i++) begin
            fetch(1'b0, below_addr(), word_t'($urandom));           // Data reads
        end
        for (int i = 0; i < 8; i++) begin
            fetch(1'b1, above_addr(), word_t'($urandom));
        end
        fetch(1'b1, {ref_limit - 16'd1, 7'h7f}, word_t'($urandom)); // Last block under
        fetch(1'b1, {ref_limit - 16'd1, 7'h00}, word_t'($urandom));
        fetch(1'b1, {ref_limit, 7'h00}, word_t'($urandom));         // First block at limit
        fetch(1'b1, {ref_limit, 7'h7f}, word_t'($urandom));
        finish_test();

        start_test("back to back 64");
        seen0 = rsp_seen;
        for (int i = 0; i < 64; i++) begin
            fetch(1'($urandom), ($urandom % 4 != 0) ? below_addr() : above_addr(),
                  word_t'($urandom));
        end
        drain();
        n_checks++;
        if (rsp_seen - seen0 != 64) begin
            value_error($sformatf("responses expected 64 seen %0d", rsp_seen - seen0));
        end
        finish_test();

        start_test("key reload");
        load_key(2);                    // key_valid checked high on every step
        for (int i = 0; i < 32; i++) begin
            fetch(($urandom % 4 != 0), ($urandom % 4 != 0) ? below_addr() : above_addr(),
                  word_t'($urandom));
        end
        finish_test();

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
src/cps2_pkg.sv
src/cps2_keyload.sv
src/cps2_range_gate.sv
src/cps2_feistel_round.sv
src/cps2_decrypt_pipe.sv
src/cps2_decrypt_top.sv
bench/cps2_decrypt_props.sv
bench/cps2_decrypt_tb.sv
